// ==== bench/tb_clock_gen.sv ====
/*
 * testbench clock and reset
 * 40 ns clock, synchronous reset held for the first 16 cycles
 */
module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // release just after the 16th rising edge
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

// ==== bench/tb_register_access_stall.sv ====
/*
 * operand hazard unit testbench
 * directed tests for source decode, pending-write counting, high-byte
 * folding and issue back-pressure of register_access_stall
 */
module tb_register_access_stall;
    timeunit 1ns;
    timeprecision 100ps;

    import opreg_pkg::*;

    localparam int RESET_TIMEOUT  = 40;
    localparam int ACCEPT_TIMEOUT = 20;

    logic       clk;
    logic       rst;
    logic       issue_valid;
    logic       next_stage_ready;
    reg_size_e  reg_size;
    op_kind_e   op0_kind;
    logic [2:0] op0_reg;
    op_kind_e   op1_kind;
    logic [2:0] op1_reg;
    logic [7:0] mod_rm;
    logic [7:0] sib;
    logic       wb_valid;
    logic [2:0] wb_reg;
    reg_size_e  wb_size;
    logic       stall;
    logic       issue_accept;

    logic [31:0] lfsr_state = 32'h12c25a08;

    tb_clock_gen clock_gen (
        .clk (clk),
        .rst (rst)
    );

    register_access_stall dut (
        .clk              (clk),
        .rst              (rst),
        .issue_valid      (issue_valid),
        .reg_size         (reg_size),
        .op0_kind         (op0_kind),
        .op0_reg          (op0_reg),
        .op1_kind         (op1_kind),
        .op1_reg          (op1_reg),
        .mod_rm           (mod_rm),
        .sib              (sib),
        .wb_valid         (wb_valid),
        .wb_reg           (wb_reg),
        .wb_size          (wb_size),
        .next_stage_ready (next_stage_ready),
        .stall            (stall),
        .issue_accept     (issue_accept)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    task automatic pick_reg(output logic [2:0] r);
        logic [7:0] v;
        take_bits(3, v);
        r = v[2:0];
    endtask

    task automatic check_equal(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, expected);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic drive_idle;
        issue_valid      = 1'b0;
        next_stage_ready = 1'b0;
        reg_size         = size_dword;
        op0_kind         = kind_none;
        op0_reg          = 3'd0;
        op1_kind         = kind_none;
        op1_reg          = 3'd0;
        mod_rm           = 8'h00;
        sib              = 8'h00;
        wb_valid         = 1'b0;
        wb_reg           = 3'd0;
        wb_size          = size_dword;
    endtask

    task automatic wait_reset_done;
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                $display("timeout: reset was never released");
                $display("Test failed");
                $fatal(1, "reset timeout");
            end
        end while (rst);
        #2;
    endtask

    // hold the presented instruction until the edge that takes it
    task automatic wait_accept;
        int cycles;
        cycles = 0;
        #10;
        while (!issue_accept) begin
            cycles++;
            if (cycles > ACCEPT_TIMEOUT) begin
                $display("timeout: instruction was never accepted");
                $display("Test failed");
                $fatal(1, "accept timeout");
            end
            next_cycle();
            #10;
        end
        next_cycle();
        drive_idle();
    endtask

    task automatic issue_write(input logic [2:0] r, input reg_size_e size);
        issue_valid      = 1'b1;
        next_stage_ready = 1'b1;
        op0_kind         = kind_reg;
        op0_reg          = r;
        reg_size         = size;
        op1_kind         = kind_none;
        wait_accept();
    endtask

    task automatic writeback(input logic [2:0] r, input reg_size_e size);
        wb_valid = 1'b1;
        wb_reg   = r;
        wb_size  = size;
        next_cycle();
        wb_valid = 1'b0;
    endtask

    // operand 1 only, so the probe itself never adds a pending write
    task automatic probe(input op_kind_e kind, input logic [2:0] r, input reg_size_e size,
                         input logic [7:0] modrm_byte, input logic [7:0] sib_byte,
                         input logic exp_stall, input string what);
        issue_valid      = 1'b1;
        next_stage_ready = 1'b1;
        op0_kind         = kind_none;
        op1_kind         = kind;
        op1_reg          = r;
        reg_size         = size;
        mod_rm           = modrm_byte;
        sib              = sib_byte;
        #10;
        check_equal(stall, exp_stall, {what, ": stall"});
        check_equal(issue_accept, !exp_stall, {what, ": issue_accept"});
        next_cycle();
        drive_idle();
    endtask

    task automatic probe_reg(input logic [2:0] r, input reg_size_e size,
                             input logic exp_stall, input string what);
        probe(kind_reg, r, size, 8'h00, 8'h00, exp_stall, what);
    endtask

    task automatic probe_modrm(input logic [7:0] modrm_byte, input logic [7:0] sib_byte,
                               input logic exp_stall, input string what);
        probe(kind_modrm, 3'd0, size_dword, modrm_byte, sib_byte, exp_stall, what);
    endtask

    task automatic after_reset_idle;
        logic [7:0] v;
        logic [2:0] dst;
        for (int k0 = 0; k0 < 7; k0++) begin
            for (int k1 = 0; k1 < 7; k1++) begin
                for (int c = 0; c < 4; c++) begin
                    take_bits(8, v);
                    mod_rm = v;
                    take_bits(8, v);
                    sib = v;
                    take_bits(3, v);
                    op0_reg = v[2:0];
                    take_bits(3, v);
                    op1_reg = v[2:0];
                    op0_kind         = op_kind_e'(k0[2:0]);
                    op1_kind         = op_kind_e'(k1[2:0]);
                    reg_size         = size_dword;
                    issue_valid      = c[1];
                    next_stage_ready = c[0];
                    dst              = op0_reg;
                    #10;
                    check_equal(stall, 1'b0, "idle stall");
                    check_equal(issue_accept, c[1] & c[0], "idle issue_accept");
                    next_cycle();
                    // an accepted register write is retired again
                    if (c == 3 && op0_kind == kind_reg) begin
                        drive_idle();
                        writeback(dst, size_dword);
                    end
                end
            end
        end
        drive_idle();
    endtask

    task automatic register_hazard;
        logic [2:0] r;
        pick_reg(r);
        issue_write(r, size_dword);
        probe_reg(r, size_dword, 1'b1, "pending register source");
        writeback(r, size_dword);
        probe_reg(r, size_dword, 1'b0, "retired register source");
    endtask

    task automatic addressing_modes;
        logic [2:0] r;
        logic [2:0] other;
        pick_reg(r);
        other = (r == 3'd0) ? 3'd1 : 3'd0;
        issue_write(r, size_dword);
        probe_modrm({2'b00, 3'b000, 3'b100}, {2'b00, 3'b100, r}, 1'b1, "sib base");
        // index 100 means no index, so register 4 cannot hit here
        probe_modrm({2'b01, 3'b000, 3'b100}, {2'b10, r, other}, r != 3'd4, "sib index");
        probe_modrm({2'b11, 3'b000, r}, 8'h00, 1'b1, "register direct");
        probe_modrm({2'b00, 3'b000, 3'b101}, {2'b00, r, r}, 1'b0, "disp32 only");
        if (r != 3'd4) begin
            issue_write(3'd4, size_dword);
        end
        probe_modrm({2'b10, 3'b000, 3'b100}, {2'b11, 3'b100, other}, 1'b0, "no index");
        writeback(r, size_dword);
        if (r != 3'd4) begin
            writeback(3'd4, size_dword);
        end
        probe_modrm({2'b00, 3'b000, 3'b100}, {2'b00, 3'b100, r}, 1'b0, "sib base retired");
    endtask

    // the second write reads r too, so it waits for the first writeback
    task automatic pending_count;
        logic [2:0] r;
        pick_reg(r);
        issue_write(r, size_dword);
        issue_valid      = 1'b1;
        next_stage_ready = 1'b1;
        op0_kind         = kind_reg;
        op0_reg          = r;
        reg_size         = size_dword;
        op1_kind         = kind_none;
        #10;
        check_equal(stall, 1'b1, "second write stall");
        check_equal(issue_accept, 1'b0, "second write issue_accept");
        next_cycle();
        wb_valid = 1'b1;
        wb_reg   = r;
        wb_size  = size_dword;
        #10;
        check_equal(stall, 1'b1, "stall during writeback");
        next_cycle();
        wb_valid = 1'b0;
        wait_accept();
        probe_reg(r, size_dword, 1'b1, "one write still pending");
        writeback(r, size_dword);
        probe_reg(r, size_dword, 1'b0, "all writes retired");
    endtask

    task automatic high_byte_fold;
        issue_write(3'd7, size_byte);
        probe_reg(3'd3, size_dword, 1'b1, "folded dword source");
        probe_reg(3'd7, size_dword, 1'b0, "dword source 7");
        writeback(3'd7, size_byte);
        probe_reg(3'd3, size_dword, 1'b0, "folded source retired");
    endtask

    task automatic back_pressure;
        logic [2:0] r;
        logic [2:0] s;
        pick_reg(r);
        s = r ^ 3'b001;
        issue_valid      = 1'b1;
        next_stage_ready = 1'b0;
        op0_kind         = kind_reg;
        op0_reg          = r;
        reg_size         = size_dword;
        op1_kind         = kind_none;
        repeat (3) begin
            #10;
            check_equal(stall, 1'b0, "not ready stall");
            check_equal(issue_accept, 1'b0, "not ready issue_accept");
            next_cycle();
        end
        drive_idle();
        probe_reg(r, size_dword, 1'b0, "refused write not counted");
        // a stalled instruction must not count its destination either
        issue_write(r, size_dword);
        issue_valid      = 1'b1;
        next_stage_ready = 1'b1;
        op0_kind         = kind_reg;
        op0_reg          = s;
        op1_kind         = kind_reg;
        op1_reg          = r;
        repeat (3) begin
            #10;
            check_equal(stall, 1'b1, "hazard stall");
            check_equal(issue_accept, 1'b0, "hazard issue_accept");
            next_cycle();
        end
        drive_idle();
        writeback(r, size_dword);
        probe_reg(s, size_dword, 1'b0, "stalled write not counted");
    endtask

    initial begin
        drive_idle();
        wait_reset_done();
        after_reset_idle();
        register_hazard();
        addressing_modes();
        pending_count();
        high_byte_fold();
        back_pressure();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== design/hazard_check.sv ====
/*
 * hazard check
 * looks up the pending-write count of every valid source register and
 * stalls issue while any of them still has a write outstanding
 */
`include "opreg_consts.svh"

module hazard_check (
    input  logic                               issue_valid,
    input  logic                               next_stage_ready,
    input  logic [`NUM_GPR*`PEND_CNT_W-1:0]    pend_counts,
    input  logic [`GPR_IDX_W-1:0]              op0_src0_idx,
    input  logic                               op0_src0_valid,
    input  logic [`GPR_IDX_W-1:0]              op0_src1_idx,
    input  logic                               op0_src1_valid,
    input  logic [`GPR_IDX_W-1:0]              op1_src0_idx,
    input  logic                               op1_src0_valid,
    input  logic [`GPR_IDX_W-1:0]              op1_src1_idx,
    input  logic                               op1_src1_valid,
    output logic                               stall,
    output logic                               issue_accept
);

    logic [`GPR_IDX_W-1:0]  src_idx [4];
    logic [3:0]             src_valid;
    logic [3:0]             src_busy;

    assign src_idx[0] = op0_src0_idx;
    assign src_idx[1] = op0_src1_idx;
    assign src_idx[2] = op1_src0_idx;
    assign src_idx[3] = op1_src1_idx;

    assign src_valid = {op1_src1_valid, op1_src0_valid, op0_src1_valid, op0_src0_valid};

    // one counter mux per source slot
    for (genvar s = 0; s < 4; s++) begin : g_src
        logic [`PEND_CNT_W-1:0] cnt_sel;

        assign cnt_sel     = pend_counts[src_idx[s]*`PEND_CNT_W +: `PEND_CNT_W];
        assign src_busy[s] = src_valid[s] && (cnt_sel != '0);
    end

    assign stall        = issue_valid && (|src_busy);
    assign issue_accept = issue_valid && next_stage_ready && !stall;

    // a stalled instruction must never be counted by the table
    always_comb begin
        assert (!(issue_accept && stall))
            else $error("hazard_check: issue accepted while stalled");
    end

endmodule

// ==== design/operand_source_decode.sv ====
/*
 * operand source decode
 * finds up to two source registers read by one operand (register,
 * memory or ModRM/SIB addressing) and whether it names a destination GPR
 */
`include "opreg_consts.svh"

module operand_source_decode (
    input  opreg_pkg::op_kind_e     op_kind,
    input  logic [`GPR_IDX_W-1:0]   op_reg,
    input  opreg_pkg::reg_size_e    reg_size,
    input  logic [7:0]              mod_rm,
    input  logic [7:0]              sib,
    output logic [`GPR_IDX_W-1:0]   src0_idx,
    output logic                    src0_valid,
    output logic [`GPR_IDX_W-1:0]   src1_idx,
    output logic                    src1_valid,
    output logic [`GPR_IDX_W-1:0]   dest_idx,
    output logic                    dest_is_reg
);

    import opreg_pkg::*;

    logic [1:0]             mod_f;
    logic [2:0]             rm_f;
    logic [2:0]             sib_index;
    logic [2:0]             sib_base;
    logic [`GPR_IDX_W-1:0]  reg_folded;
    logic                   has_sib;
    logic                   disp_only;

    assign mod_f     = mod_rm[`MODRM_MOD_HI:`MODRM_MOD_LO];
    assign rm_f      = mod_rm[`MODRM_RM_HI:`MODRM_RM_LO];
    assign sib_index = sib[`SIB_INDEX_HI:`SIB_INDEX_LO];
    assign sib_base  = sib[`SIB_BASE_HI:`SIB_BASE_LO];

    assign reg_folded = fold_gpr_index(op_reg, reg_size);

    // memory form with rm 100 pulls in a SIB byte
    assign has_sib   = (mod_f != `MODRM_MOD_REG) && (rm_f == `MODRM_RM_SIB);
    // mod 00 rm 101 is a bare disp32 with no register read
    assign disp_only = (mod_f == 2'b00) && (rm_f == `DISP32_RM);

    // first source
    always_comb begin
        src0_idx   = reg_folded;
        src0_valid = 1'b0;
        case (op_kind)
            kind_reg, kind_mem: begin
                src0_valid = 1'b1;
            end
            kind_modrm: begin
                src0_valid = !disp_only;
                src0_idx   = has_sib ? sib_base : rm_f;
            end
            default: begin
                src0_valid = 1'b0;
            end
        endcase
    end

    // second source is only ever the SIB index
    assign src1_idx   = sib_index;
    assign src1_valid = (op_kind == kind_modrm) && has_sib &&
                        (sib_index != `SIB_NO_INDEX);

    // only a plain register operand is a tracked destination
    assign dest_is_reg = (op_kind == kind_reg);
    assign dest_idx    = reg_folded;

    // an index register is never used without a base
    always_comb begin
        assert (!src1_valid || src0_valid)
            else $error("operand_source_decode: index source without base source");
    end

endmodule

// ==== design/opreg_consts.svh ====
/*
 * operand hazard unit constants
 * register file geometry, counter sizing and ModRM / SIB field layout
 */
`ifndef OPREG_CONSTS_SVH
`define OPREG_CONSTS_SVH

`define NUM_GPR        8
`define GPR_IDX_W      3
`define PEND_CNT_W     4
`define PEND_CNT_MAX   15

// ModRM byte fields
`define MODRM_MOD_HI   7
`define MODRM_MOD_LO   6
`define MODRM_RM_HI    2
`define MODRM_RM_LO    0
`define MODRM_RM_SIB   3'b100
`define MODRM_MOD_REG  2'b11
`define DISP32_RM      3'b101

// SIB byte fields
`define SIB_INDEX_HI   5
`define SIB_INDEX_LO   3
`define SIB_BASE_HI    2
`define SIB_BASE_LO    0
`define SIB_NO_INDEX   3'b100

`endif

// ==== design/opreg_pkg.sv ====
/*
 * operand hazard unit package
 * operand kind and register size encodings, plus the high-byte
 * register fold shared by source decode and the pending-write table
 */
`include "opreg_consts.svh"

package opreg_pkg;

    // operand kind as presented by the decode stage
    typedef enum logic [2:0] {
        kind_none  = 3'd0,
        kind_reg   = 3'd1,
        kind_seg   = 3'd2,
        kind_mm    = 3'd3,
        kind_modrm = 3'd4,
        kind_imm   = 3'd5,
        kind_mem   = 3'd6
    } op_kind_e;

    // operand register width
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2
    } reg_size_e;

    // AH/CH/DH/BH live in the same GPR as AL/CL/DL/BL,
    // so byte indices 4..7 map back onto 0..3
    function automatic logic [`GPR_IDX_W-1:0] fold_gpr_index(
        input logic [`GPR_IDX_W-1:0] idx,
        input reg_size_e             size
    );
        logic [`GPR_IDX_W-1:0] folded;
        folded = idx;
        if (size == size_byte && idx >= 3'd4) begin
            folded = idx - 3'd4;
        end
        return folded;
    endfunction

endpackage

// ==== design/pending_write_table.sv ====
/*
 * pending-write table
 * one counter per GPR holding the number of issued writes not yet
 * written back; issue increments, writeback decrements
 */
`include "opreg_consts.svh"

module pending_write_table (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                issue_accept,
    input  logic                                dest_is_reg,
    input  logic [`GPR_IDX_W-1:0]               dest_idx,
    input  logic                                wb_valid,
    input  logic [`GPR_IDX_W-1:0]               wb_reg,
    input  opreg_pkg::reg_size_e                wb_size,
    output logic [`NUM_GPR*`PEND_CNT_W-1:0]     pend_counts
);

    import opreg_pkg::*;

    logic [`PEND_CNT_W-1:0]  pend_cnt [`NUM_GPR];
    logic [`GPR_IDX_W-1:0]   wb_idx;
    logic                    issue_write;

    // high-byte writebacks land on the low four registers
    assign wb_idx      = fold_gpr_index(wb_reg, wb_size);
    assign issue_write = issue_accept && dest_is_reg;

    for (genvar i = 0; i < `NUM_GPR; i++) begin : g_cnt
        logic inc_hit;
        logic dec_hit;

        assign inc_hit = issue_write && (dest_idx == i);
        assign dec_hit = wb_valid && (wb_idx == i);

        // same-cycle issue and writeback cancel out
        always_ff @(posedge clk) begin
            if (rst) begin
                pend_cnt[i] <= '0;
            end else if (inc_hit && !dec_hit) begin
                if (pend_cnt[i] != `PEND_CNT_MAX) begin
                    pend_cnt[i] <= pend_cnt[i] + 1'b1;
                end
            end else if (dec_hit && !inc_hit) begin
                if (pend_cnt[i] != '0) begin
                    pend_cnt[i] <= pend_cnt[i] - 1'b1;
                end
            end
        end

        assign pend_counts[i*`PEND_CNT_W +: `PEND_CNT_W] = pend_cnt[i];

        // decode stage must not issue past counter capacity
        a_no_overflow: assert property (
            @(posedge clk) disable iff (rst)
            (inc_hit && !dec_hit) |-> (pend_cnt[i] != `PEND_CNT_MAX)
        ) else $error("pending_write_table: counter %0d overflow", i);

        // writeback for a register with nothing outstanding
        a_no_underflow: assert property (
            @(posedge clk) disable iff (rst)
            (dec_hit && !inc_hit) |-> (pend_cnt[i] != '0)
        ) else $error("pending_write_table: counter %0d underflow", i);
    end

endmodule

// ==== design/register_access_stall.sv ====
/*
 * register access stall
 * operand hazard unit for the decode stage; decodes the sources of both
 * operands, tracks pending GPR writes and raises stall on a hazard
 */
module register_access_stall (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_valid,
    input  opreg_pkg::reg_size_e  reg_size,
    input  opreg_pkg::op_kind_e   op0_kind,
    input  logic [2:0]            op0_reg,
    input  opreg_pkg::op_kind_e   op1_kind,
    input  logic [2:0]            op1_reg,
    input  logic [7:0]            mod_rm,
    input  logic [7:0]            sib,
    input  logic                  wb_valid,
    input  logic [2:0]            wb_reg,
    input  opreg_pkg::reg_size_e  wb_size,
    input  logic                  next_stage_ready,
    output logic                  stall,
    output logic                  issue_accept
);

    logic [2:0]   op0_src0_idx;
    logic         op0_src0_valid;
    logic [2:0]   op0_src1_idx;
    logic         op0_src1_valid;
    logic [2:0]   op1_src0_idx;
    logic         op1_src0_valid;
    logic [2:0]   op1_src1_idx;
    logic         op1_src1_valid;
    logic [2:0]   dest_idx;
    logic         dest_is_reg;
    logic [31:0]  pend_counts;

    // operand 0 is both a source and the tracked destination
    operand_source_decode op0_decode (
        .op_kind     (op0_kind),
        .op_reg      (op0_reg),
        .reg_size    (reg_size),
        .mod_rm      (mod_rm),
        .sib         (sib),
        .src0_idx    (op0_src0_idx),
        .src0_valid  (op0_src0_valid),
        .src1_idx    (op0_src1_idx),
        .src1_valid  (op0_src1_valid),
        .dest_idx    (dest_idx),
        .dest_is_reg (dest_is_reg)
    );

    // operand 1 is read only
    operand_source_decode op1_decode (
        .op_kind     (op1_kind),
        .op_reg      (op1_reg),
        .reg_size    (reg_size),
        .mod_rm      (mod_rm),
        .sib         (sib),
        .src0_idx    (op1_src0_idx),
        .src0_valid  (op1_src0_valid),
        .src1_idx    (op1_src1_idx),
        .src1_valid  (op1_src1_valid),
        .dest_idx    (),
        .dest_is_reg ()
    );

    pending_write_table table_inst (
        .clk          (clk),
        .rst          (rst),
        .issue_accept (issue_accept),
        .dest_is_reg  (dest_is_reg),
        .dest_idx     (dest_idx),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_size      (wb_size),
        .pend_counts  (pend_counts)
    );

    hazard_check check_inst (
        .issue_valid      (issue_valid),
        .next_stage_ready (next_stage_ready),
        .pend_counts      (pend_counts),
        .op0_src0_idx     (op0_src0_idx),
        .op0_src0_valid   (op0_src0_valid),
        .op0_src1_idx     (op0_src1_idx),
        .op0_src1_valid   (op0_src1_valid),
        .op1_src0_idx     (op1_src0_idx),
        .op1_src0_valid   (op1_src0_valid),
        .op1_src1_idx     (op1_src1_idx),
        .op1_src1_valid   (op1_src1_valid),
        .stall            (stall),
        .issue_accept     (issue_accept)
    );

endmodule

// ==== register_access_stall.f ====
+incdir+design
design/opreg_pkg.sv
design/operand_source_decode.sv
design/pending_write_table.sv
design/hazard_check.sv
design/register_access_stall.sv
bench/tb_clock_gen.sv
bench/tb_register_access_stall.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the operand hazard unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f register_access_stall.f \
    --top-module tb_register_access_stall \
    -Mdir obj_dir \
    && ./obj_dir/Vtb_register_access_stall \
    || { echo "simulation failed"; exit 1; }
